//--- list.f
synth_pkg.sv
midi_uart_rx.sv
midi_decoder.sv
voice_allocator.sv
synth_regs.sv
voice_engine.sv
synthesizer.sv
synth_checker.sv
tb_synthesizer.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the synthesizer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_synthesizer -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    exit 1
fi
exit 0

//--- tb_synthesizer.sv
/*
 * synthesizer testbench
 * MIDI serial driver, CPU bus tasks, watchdog and directed/random note sequence
 */
`timescale 1ns/100ps

module tb_synthesizer import synth_pkg::*; ();

    localparam int MSG_BYTES  = 50;     // upper bound on bytes sent below
    localparam int TICK_WAITS = 250;    // upper bound on sample ticks waited
    localparam int WATCHDOG_CYCLES =
        MSG_BYTES * 10 * MIDI_BIT_CLKS + TICK_WAITS * SAMPLE_DIV + 50000;

    logic                     CLOCK_50;
    logic                     io_reset;
    logic                     midi_rxd;
    logic                     chipselect;
    logic                     cpu_read;
    logic                     cpu_write;
    logic [1:0]               address;
    logic [31:0]              cpu_wdata;
    logic [31:0]              cpu_rdata;
    logic [AUD_BIT_DEPTH-1:0] lsound_out;
    logic [AUD_BIT_DEPTH-1:0] rsound_out;
    logic [VOICES-1:0]        keys_on;
    logic                     sample_tick;
    logic                     ev_valid;
    logic                     ev_on;
    logic [6:0]               ev_key;
    logic [6:0]               ev_vel;
    logic                     ev_flush;
    int                       keys_err;
    int                       audio_err;
    int                       reg_err;
    int                       seed;
    logic [6:0]               rnd_key [9];
    logic [6:0]               rnd_vel;

    synthesizer dut (.*);

    synth_checker chk (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("timeout: test sequence did not finish in %0d clock cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic step();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic wait_ticks(input int n);
        repeat (n) begin
            do
                step();
            while (!sample_tick);
        end
    endtask

    // 8N1 frame, LSB first
    task automatic send_midi(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            midi_rxd = frame[i];
            repeat (MIDI_BIT_CLKS) step();
        end
    endtask

    // heard = message is on the selected channel, model gets the event
    task automatic play_note(input logic [7:0] status, input bit with_status,
                             input logic [6:0] k, input logic [6:0] v, input bit heard);
        if (heard) begin
            ev_valid = 1'b1;
            ev_on    = (status[7:4] == 4'h9) && (v != 7'd0);
            ev_key   = k;
            ev_vel   = v;
            step();
            ev_valid = 1'b0;
        end
        if (with_status)
            send_midi(status);
        send_midi({1'b0, k});
        send_midi({1'b0, v});
        repeat (4) step();
        ev_flush = 1'b1;
        step();
        ev_flush = 1'b0;
    endtask

    task automatic cpu_wr(input logic [1:0] addr, input logic [31:0] data);
        chipselect = 1'b1;
        cpu_write  = 1'b1;
        address    = addr;
        cpu_wdata  = data;
        step();
        chipselect = 1'b0;
        cpu_write  = 1'b0;
        step();
    endtask

    // checker compares the returned data
    task automatic cpu_rd(input logic [1:0] addr);
        chipselect = 1'b1;
        cpu_read   = 1'b1;
        address    = addr;
        step();
        chipselect = 1'b0;
        cpu_read   = 1'b0;
        step();
        step();
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed       = 19;
        io_reset   = 1'b1;
        midi_rxd   = 1'b1;
        chipselect = 1'b0;
        cpu_read   = 1'b0;
        cpu_write  = 1'b0;
        address    = 2'd0;
        cpu_wdata  = 32'd0;
        ev_valid   = 1'b0;
        ev_on      = 1'b0;
        ev_key     = 7'd0;
        ev_vel     = 7'd0;
        ev_flush   = 1'b0;
        repeat (8) step();
        io_reset = 1'b0;

        // idle after reset
        wait_ticks(3);
        cpu_rd(2'd0);
        cpu_rd(2'd3);

        // single note left, then running status to voice 1
        play_note(8'h90, 1'b1, 7'd60, 7'd100, 1'b1);
        wait_ticks(40);
        play_note(8'h90, 1'b0, 7'd64, 7'd80, 1'b1);
        wait_ticks(20);
        play_note(8'h90, 1'b0, 7'd60, 7'd0, 1'b1);     // velocity 0 is a note-off
        wait_ticks(10);
        play_note(8'h80, 1'b1, 7'd64, 7'd40, 1'b1);
        wait_ticks(5);

        // channel select
        cpu_wr(2'd0, 32'd5);
        cpu_rd(2'd0);
        play_note(8'h90, 1'b1, 7'd50, 7'd90, 1'b0);
        wait_ticks(5);
        play_note(8'h95, 1'b1, 7'd50, 7'd90, 1'b1);
        wait_ticks(10);
        cpu_rd(2'd2);
        cpu_rd(2'd3);
        play_note(8'h85, 1'b1, 7'd50, 7'd0, 1'b1);
        wait_ticks(5);

        // fill all voices, ninth note is dropped
        for (int i = 0; i < 9; i++) begin
            rnd_key[i] = 7'($random(seed));
            rnd_vel    = 7'(($random(seed) & 32'h3f) + 1);
            play_note(8'h95, (i == 0), rnd_key[i], rnd_vel, 1'b1);
        end
        wait_ticks(10);
        cpu_rd(2'd2);
        cpu_rd(2'd3);
        play_note(8'h85, 1'b1, rnd_key[3], 7'd0, 1'b1);
        wait_ticks(5);
        play_note(8'h95, 1'b1, 7'd33, 7'd70, 1'b1);
        wait_ticks(10);
        cpu_rd(2'd2);
        cpu_rd(2'd3);

        // mute and resume, writes placed right after a tick
        wait_ticks(1);
        cpu_wr(2'd1, 32'd0);
        wait_ticks(6);
        cpu_rd(2'd1);
        cpu_rd(2'd2);
        wait_ticks(1);
        cpu_wr(2'd1, 32'd1);
        wait_ticks(8);

        $display("errors: keys_on %0d, audio %0d, register reads %0d",
                 keys_err, audio_err, reg_err);
        if (keys_err + audio_err + reg_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- synth_checker.sv
/*
 * synthesizer checker
 * reference voice model fed with note events
 * compares audio, tick spacing, keys and register reads
 */
`timescale 1ns/100ps

module synth_checker import synth_pkg::*; (
    input  logic                      CLOCK_50,
    input  logic                      io_reset,
    input  logic [AUD_BIT_DEPTH-1:0]  lsound_out,
    input  logic [AUD_BIT_DEPTH-1:0]  rsound_out,
    input  logic [VOICES-1:0]         keys_on,
    input  logic                      sample_tick,
    input  logic                      chipselect,
    input  logic                      cpu_read,
    input  logic                      cpu_write,
    input  logic [1:0]                address,
    input  logic [31:0]               cpu_wdata,
    input  logic [31:0]               cpu_rdata,
    input  logic                      ev_valid,     // note event posted by the testbench
    input  logic                      ev_on,
    input  logic [6:0]                ev_key,
    input  logic [6:0]                ev_vel,
    input  logic                      ev_flush,     // message fully sent
    output int                        keys_err,
    output int                        audio_err,
    output int                        reg_err
);

    logic [VOICES-1:0]      m_keys;
    logic [6:0]             m_key [VOICES];
    logic [6:0]             m_vel [VOICES];
    logic [PHASE_WIDTH-1:0] m_phase [VOICES];
    logic [3:0]             m_ch;
    logic                   m_run;
    logic [VOICES-1:0]      last_keys;
    logic                   pend;
    logic                   pend_on;
    logic [6:0]             pend_key;
    logic [6:0]             pend_vel;
    logic                   rd_pend;
    logic [1:0]             rd_addr;
    logic                   changed;
    int                     tick_gap;       // clocks since the last tick
    logic                   tick_seen;

    initial begin
        keys_err  = 0;
        audio_err = 0;
        reg_err   = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // expected sample for one side where odd means right
    function automatic logic [AUD_BIT_DEPTH-1:0] mix_ref(input int odd);
        int sum;
        int amp;
        sum = 0;
        for (int i = 0; i < VOICES; i++) begin
            if (m_keys[i] && (i % 2 == odd)) begin
                amp = int'(m_vel[i]) * (1 << AMP_SHIFT);
                if (m_phase[i][PHASE_WIDTH-1])
                    sum = sum - amp;
                else
                    sum = sum + amp;
            end
        end
        if (!m_run)
            sum = 0;
        return AUD_BIT_DEPTH'(sum);
    endfunction

    function automatic logic [31:0] reg_ref(input logic [1:0] addr);
        int cnt;
        cnt = 0;
        for (int i = 0; i < VOICES; i++)
            cnt = cnt + int'(m_keys[i]);
        case (addr)
            2'd0:    return 32'(m_ch);
            2'd1:    return 32'(m_run);
            2'd2:    return 32'(m_keys);
            default: return 32'(cnt);
        endcase
    endfunction

    task automatic apply_event();
        int slot;
        slot = -1;
        if (pend_on) begin
            for (int i = VOICES - 1; i >= 0; i--)
                if (!m_keys[i])
                    slot = i;
            if (slot >= 0) begin        // no free voice drops the note
                m_keys[slot]  = 1'b1;
                m_key[slot]   = pend_key;
                m_vel[slot]   = pend_vel;
                m_phase[slot] = '0;
            end
        end else begin
            for (int i = 0; i < VOICES; i++)
                if (m_keys[i] && m_key[i] == pend_key)
                    m_keys[i] = 1'b0;
        end
        pend = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare at the falling edge once DUT outputs have settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLOCK_50) begin
        if (io_reset) begin
            m_keys    = '0;
            m_ch      = 4'd0;
            m_run     = 1'b1;
            last_keys = '0;
            pend      = 1'b0;
            rd_pend   = 1'b0;
            tick_gap  = 0;
            tick_seen = 1'b0;
        end else begin
            tick_gap++;
            if (sample_tick) begin
                // one tick pulse every SAMPLE_DIV clocks
                if (tick_seen && tick_gap != SAMPLE_DIV) begin
                    audio_err++;
                    $display("ERR %0t sample_tick period expected %0d actual %0d",
                             $time, SAMPLE_DIV, tick_gap);
                end
                tick_seen = 1'b1;
                tick_gap  = 0;
                if (lsound_out !== mix_ref(0)) begin
                    audio_err++;
                    $display("ERR %0t lsound_out expected %h actual %h",
                             $time, mix_ref(0), lsound_out);
                end
                if (rsound_out !== mix_ref(1)) begin
                    audio_err++;
                    $display("ERR %0t rsound_out expected %h actual %h",
                             $time, mix_ref(1), rsound_out);
                end
                for (int i = 0; i < VOICES; i++)     // phases step after the sample
                    if (m_keys[i])
                        m_phase[i] = m_phase[i] + (PHASE_WIDTH'(m_key[i]) + 16'd1) * 16'd64;
            end
            if (rd_pend && cpu_rdata !== reg_ref(rd_addr)) begin
                reg_err++;
                $display("ERR %0t cpu_rdata expected %h actual %h",
                         $time, reg_ref(rd_addr), cpu_rdata);
            end
            rd_pend = chipselect && cpu_read;
            rd_addr = address;
            if (chipselect && cpu_write) begin
                if (address == 2'd0)
                    m_ch = cpu_wdata[3:0];
                else if (address == 2'd1)
                    m_run = cpu_wdata[0];
            end
            if (ev_valid) begin
                pend     = 1'b1;
                pend_on  = ev_on;
                pend_key = ev_key;
                pend_vel = ev_vel;
            end
            changed = (keys_on != last_keys);
            if (pend && (changed || ev_flush))
                apply_event();
            if ((changed || ev_flush) && keys_on !== m_keys) begin
                keys_err++;
                $display("ERR %0t keys_on expected %b actual %b", $time, m_keys, keys_on);
            end
            last_keys = keys_on;
        end
    end

endmodule

//--- synthesizer.sv
/*
 * two channel MIDI synthesizer top level
 * receiver, note decoder, CPU registers, voice allocator and voice engine
 */
`timescale 1ns/100ps

module synthesizer import synth_pkg::*; (
    input  logic                      CLOCK_50,
    input  logic                      io_reset,
    input  logic                      midi_rxd,     // MIDI serial in
    // CPU bus
    input  logic                      chipselect,
    input  logic                      cpu_read,
    input  logic                      cpu_write,
    input  logic [1:0]                address,
    input  logic [31:0]               cpu_wdata,
    output logic [31:0]               cpu_rdata,
    // audio and status
    output logic [AUD_BIT_DEPTH-1:0]  lsound_out,
    output logic [AUD_BIT_DEPTH-1:0]  rsound_out,
    output logic [VOICES-1:0]         keys_on,
    output logic                      sample_tick
);

    logic [7:0]              rx_byte;
    logic                    byte_valid;
    logic [3:0]              midi_ch;
    logic                    run;
    logic                    note_on;
    logic                    note_off;
    logic [6:0]              key;
    logic [6:0]              velocity;
    logic [VOICES-1:0][6:0]  voice_key;
    logic [VOICES-1:0][6:0]  voice_vel;

    //////////////////////////////////////////////////////////////////////
    // MIDI in
    //////////////////////////////////////////////////////////////////////

    midi_uart_rx midi_uart_rx_inst (
        .CLOCK_50   (CLOCK_50),
        .io_reset   (io_reset),
        .midi_rxd   (midi_rxd),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    midi_decoder midi_decoder_inst (
        .CLOCK_50   (CLOCK_50),
        .io_reset   (io_reset),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .midi_ch    (midi_ch),      // from CPU regs
        .note_on    (note_on),
        .note_off   (note_off),
        .key        (key),
        .velocity   (velocity)
    );

    synth_regs synth_regs_inst (
        .CLOCK_50   (CLOCK_50),
        .io_reset   (io_reset),
        .chipselect (chipselect),
        .cpu_read   (cpu_read),
        .cpu_write  (cpu_write),
        .address    (address),
        .cpu_wdata  (cpu_wdata),
        .keys_on    (keys_on),
        .cpu_rdata  (cpu_rdata),
        .midi_ch    (midi_ch),
        .run        (run)
    );

    //////////////////////////////////////////////////////////////////////
    // sound generation
    //////////////////////////////////////////////////////////////////////

    voice_allocator voice_allocator_inst (
        .CLOCK_50   (CLOCK_50),
        .io_reset   (io_reset),
        .note_on    (note_on),
        .note_off   (note_off),
        .key        (key),
        .velocity   (velocity),
        .keys_on    (keys_on),
        .voice_key  (voice_key),
        .voice_vel  (voice_vel)
    );

    voice_engine voice_engine_inst (
        .CLOCK_50    (CLOCK_50),
        .io_reset    (io_reset),
        .run         (run),
        .keys_on     (keys_on),
        .voice_key   (voice_key),
        .voice_vel   (voice_vel),
        .lsound_out  (lsound_out),    // even voices
        .rsound_out  (rsound_out),    // odd voices
        .sample_tick (sample_tick)
    );

endmodule

//--- voice_engine.sv
/*
 * square wave voice engine
 * one phase accumulator per voice, even voices mixed left and odd voices right
 */
`timescale 1ns/100ps

module voice_engine import synth_pkg::*; (
    input  logic                      CLOCK_50,
    input  logic                      io_reset,
    input  logic                      run,
    input  logic [VOICES-1:0]         keys_on,
    input  logic [VOICES-1:0][6:0]    voice_key,
    input  logic [VOICES-1:0][6:0]    voice_vel,
    output logic [AUD_BIT_DEPTH-1:0]  lsound_out,
    output logic [AUD_BIT_DEPTH-1:0]  rsound_out,
    output logic                      sample_tick
);

    logic [9:0]                         div_cnt;
    logic                               tick;
    logic [VOICES-1:0][PHASE_WIDTH-1:0] phase;
    logic signed [AUD_BIT_DEPTH-1:0]    amp;
    logic signed [AUD_BIT_DEPTH-1:0]    lsum;
    logic signed [AUD_BIT_DEPTH-1:0]    rsum;

    //////////////////////////////////////////////////////////////////////
    // sample rate divider
    //////////////////////////////////////////////////////////////////////

    assign tick = (div_cnt == 10'(SAMPLE_DIV - 1));

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            div_cnt     <= 10'd0;
            sample_tick <= 1'b0;
        end else begin
            div_cnt     <= tick ? 10'd0 : div_cnt + 10'd1;
            sample_tick <= tick;    // high while the new sample is on the outputs
        end
    end

    //////////////////////////////////////////////////////////////////////
    // phase accumulators, step is (key + 1) << 6
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK_50) begin
        for (int i = 0; i < VOICES; i++) begin
            if (io_reset || !keys_on[i])
                phase[i] <= '0;             // idle voice waits at phase 0
            else if (tick)
                phase[i] <= phase[i] + (PHASE_WIDTH'({1'b0, voice_key[i]} + 8'd1) << 6);
        end
    end

    // mixer, square wave sign from phase MSB
    always_comb begin
        lsum = '0;
        rsum = '0;
        amp  = '0;
        for (int i = 0; i < VOICES; i++) begin
            if (keys_on[i]) begin
                amp = AUD_BIT_DEPTH'(voice_vel[i]) << AMP_SHIFT;
                if (phase[i][PHASE_WIDTH-1])
                    amp = -amp;
                if (i % 2 == 0)
                    lsum = lsum + amp;
                else
                    rsum = rsum + amp;
            end
        end
    end

    // output registers, phases keep running while muted
    always_ff @(posedge CLOCK_50) begin
        if (io_reset || !run) begin
            lsound_out <= '0;
            rsound_out <= '0;
        end else if (tick) begin
            lsound_out <= lsum;
            rsound_out <= rsum;
        end
    end

endmodule

//--- synth_regs.sv
/*
 * CPU register block
 * MIDI channel and run enable, plus voice status readback
 */
`timescale 1ns/100ps

module synth_regs import synth_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              io_reset,
    input  logic              chipselect,
    input  logic              cpu_read,
    input  logic              cpu_write,
    input  logic [1:0]        address,
    input  logic [31:0]       cpu_wdata,
    input  logic [VOICES-1:0] keys_on,
    output logic [31:0]       cpu_rdata,
    output logic [3:0]        midi_ch,
    output logic              run
);

    reg_addr_t          reg_sel;
    logic [V_WIDTH:0]   voice_cnt;      // 0..VOICES

    assign reg_sel = reg_addr_t'(address);

    // population count of active voices
    always_comb begin
        voice_cnt = '0;
        for (int i = 0; i < VOICES; i++)
            voice_cnt = voice_cnt + (V_WIDTH + 1)'(keys_on[i]);
    end

    //////////////////////////////////////////////////////////////////////
    // writes take effect on the strobe edge
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            midi_ch <= 4'd0;
            run     <= 1'b1;    // sound on out of reset
        end else if (chipselect && cpu_write) begin
            case (reg_sel)
                REG_CHANNEL: midi_ch <= cpu_wdata[3:0];
                REG_RUN:     run     <= cpu_wdata[0];
                default: ;      // status regs are read only
            endcase
        end
    end

    // read data valid the cycle after the strobe
    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            cpu_rdata <= 32'd0;
        end else if (chipselect && cpu_read) begin
            case (reg_sel)
                REG_CHANNEL: cpu_rdata <= 32'(midi_ch);
                REG_RUN:     cpu_rdata <= 32'(run);
                REG_KEYS:    cpu_rdata <= 32'(keys_on);
                REG_VCOUNT:  cpu_rdata <= 32'(voice_cnt);
                default:     cpu_rdata <= 32'd0;
            endcase
        end
    end

endmodule

//--- voice_allocator.sv
/*
 * voice table
 * note-on takes the lowest free voice, note-off frees every voice on that key
 */
`timescale 1ns/100ps

module voice_allocator import synth_pkg::*; (
    input  logic                    CLOCK_50,
    input  logic                    io_reset,
    input  logic                    note_on,
    input  logic                    note_off,
    input  logic [6:0]              key,
    input  logic [6:0]              velocity,
    output logic [VOICES-1:0]       keys_on,
    output logic [VOICES-1:0][6:0]  voice_key,
    output logic [VOICES-1:0][6:0]  voice_vel
);

    logic [V_WIDTH-1:0] free_idx;
    logic               any_free;
    logic [VOICES-1:0]  off_hit;
    logic               take_voice;

    //////////////////////////////////////////////////////////////////////
    // priority search, lowest index wins
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (!keys_on[i]) begin
                any_free = 1'b1;
                free_idx = V_WIDTH'(i);
            end
        end
    end

    // key compare across all voices
    always_comb begin
        for (int i = 0; i < VOICES; i++)
            off_hit[i] = keys_on[i] && (voice_key[i] == key);
    end

    assign take_voice = note_on && any_free;   // full table drops the note

    //////////////////////////////////////////////////////////////////////
    // voice state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            keys_on <= '0;
        end else if (note_off) begin
            keys_on <= keys_on & ~off_hit;
        end else if (take_voice) begin
            keys_on[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (take_voice) begin
            voice_key[free_idx] <= key;
            voice_vel[free_idx] <= velocity;
        end
    end

endmodule

//--- midi_decoder.sv
/*
 * MIDI note message parser with running status
 * emits note_on / note_off strobes for the selected channel only
 */
`timescale 1ns/100ps

module midi_decoder import synth_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       io_reset,
    input  logic [7:0] rx_byte,
    input  logic       byte_valid,
    input  logic [3:0] midi_ch,
    output logic       note_on,
    output logic       note_off,
    output logic [6:0] key,
    output logic [6:0] velocity
);

    dec_state_t state;
    logic       stat_on;        // running status is 9n rather than 8n
    logic       ch_match;       // running status is on our channel
    logic [6:0] key_hold;
    logic       is_status;
    logic       is_note_stat;
    logic       vel_zero;

    assign is_status    = rx_byte[7];
    assign is_note_stat = (rx_byte[7:4] == 4'h9) || (rx_byte[7:4] == 4'h8);
    assign vel_zero     = (rx_byte[6:0] == 7'd0);

    //////////////////////////////////////////////////////////////////////
    // parser FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            state    <= DEC_IDLE;
            stat_on  <= 1'b0;
            ch_match <= 1'b0;
            note_on  <= 1'b0;
            note_off <= 1'b0;
        end else begin
            note_on  <= 1'b0;
            note_off <= 1'b0;
            if (byte_valid) begin
                if (is_status) begin
                    if (is_note_stat) begin
                        state    <= DEC_KEY;
                        stat_on  <= rx_byte[4];
                        ch_match <= (rx_byte[3:0] == midi_ch);
                    end else begin
                        state <= DEC_IDLE;      // anything else kills running status
                    end
                end else begin
                    case (state)
                        DEC_KEY: state <= DEC_VEL;
                        DEC_VEL: begin
                            state    <= DEC_KEY;    // stay ready for running status
                            note_on  <= ch_match && stat_on && !vel_zero;
                            note_off <= ch_match && (!stat_on || vel_zero);
                        end
                        default: ;                  // stray data byte
                    endcase
                end
            end
        end
    end

    // message payload
    always_ff @(posedge CLOCK_50) begin
        if (byte_valid && !is_status) begin
            if (state == DEC_KEY)
                key_hold <= rx_byte[6:0];
            if (state == DEC_VEL) begin
                key      <= key_hold;
                velocity <= rx_byte[6:0];
            end
        end
    end

endmodule

//--- midi_uart_rx.sv
/*
 * MIDI serial receiver, 8N1 at 31250 baud
 * samples each bit at its centre and pulses byte_valid per good frame
 */
`timescale 1ns/100ps

module midi_uart_rx import synth_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       io_reset,
    input  logic       midi_rxd,
    output logic [7:0] rx_byte,
    output logic       byte_valid
);

    logic        rxd_meta;
    logic        rxd_s;         // synchronized line
    logic        busy;
    logic [3:0]  bit_idx;       // 0 start, 1..8 data, 9 stop
    logic [10:0] bit_cnt;       // clocks left to next sample point
    logic [7:0]  shreg;
    logic        sample_now;

    // idle line is high
    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
        end else begin
            rxd_meta <= midi_rxd;
            rxd_s    <= rxd_meta;
        end
    end

    assign sample_now = busy && (bit_cnt == 11'd0);

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            busy       <= 1'b0;
            bit_idx    <= 4'd0;
            bit_cnt    <= 11'd0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!busy) begin
                if (!rxd_s) begin               // falling edge of start bit
                    busy    <= 1'b1;
                    bit_idx <= 4'd0;
                    bit_cnt <= 11'(MIDI_BIT_CLKS / 2 - 1);  // aim for mid-bit
                end
            end else if (!sample_now) begin
                bit_cnt <= bit_cnt - 11'd1;
            end else begin
                bit_cnt <= 11'(MIDI_BIT_CLKS - 1);
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0 && rxd_s) begin
                    busy <= 1'b0;               // glitch, not a real start
                end else if (bit_idx == 4'd9) begin
                    busy       <= 1'b0;
                    byte_valid <= rxd_s;        // framing error drops the byte
                end
            end
        end
    end

    // data path, LSB first
    always_ff @(posedge CLOCK_50) begin
        if (sample_now && bit_idx >= 4'd1 && bit_idx <= 4'd8)
            shreg <= {rxd_s, shreg[7:1]};
        if (sample_now && bit_idx == 4'd9 && rxd_s)
            rx_byte <= shreg;
    end

endmodule

//--- synth_pkg.sv
/*
 * synthesizer shared definitions
 * timing constants, voice sizing, decoder states and register map
 */

package synth_pkg;

    //////////////////////////////////////////////////////////////////////
    // voice sizing
    //////////////////////////////////////////////////////////////////////

    localparam int VOICES  = 8;     // total voices, even ones left, odd ones right
    localparam int V_WIDTH = 3;     // voice index width

    //////////////////////////////////////////////////////////////////////
    // timing at 50 MHz
    //////////////////////////////////////////////////////////////////////

    localparam int MIDI_BIT_CLKS = 1600;    // 31250 baud
    localparam int SAMPLE_DIV    = 1024;    // clocks per audio sample

    //////////////////////////////////////////////////////////////////////
    // audio path
    //////////////////////////////////////////////////////////////////////

    localparam int AUD_BIT_DEPTH = 24;
    localparam int PHASE_WIDTH   = 16;
    // 7-bit velocity lands at bits 18:12, leaves headroom for 4 voices
    localparam int AMP_SHIFT     = 12;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // MIDI parser states
    typedef enum logic [1:0] {
        DEC_IDLE = 2'd0,    // no usable running status
        DEC_KEY  = 2'd1,    // expecting key number
        DEC_VEL  = 2'd2     // expecting velocity
    } dec_state_t;

    // CPU register map
    typedef enum logic [1:0] {
        REG_CHANNEL = 2'd0,     // rw, MIDI receive channel
        REG_RUN     = 2'd1,     // rw, audio output enable
        REG_KEYS    = 2'd2,     // ro, active voice mask
        REG_VCOUNT  = 2'd3      // ro, number of active voices
    } reg_addr_t;

endpackage
